//--- hdl/mmu_pkg.sv
package mmu_pkg;

   //////////////////////////////
   // widths
   localparam int xlen        = 32;
   localparam int vpn_w       = 20;
   localparam int ppn_w       = 22;
   localparam int offset_w    = 12;
   localparam int tlb_entries = 16;
   localparam int tlb_idx_w   = 4;

   // page fault causes
   localparam logic [4:0] cause_fetch_pf = 5'd12;
   localparam logic [4:0] cause_load_pf  = 5'd13;
   localparam logic [4:0] cause_store_pf = 5'd15;

   // pte flag positions
   localparam int pte_v = 0;
   localparam int pte_r = 1;
   localparam int pte_w = 2;
   localparam int pte_x = 3;
   localparam int pte_u = 4;
   localparam int pte_a = 6;
   localparam int pte_d = 7;

   //////////////////////////////
   // types
   typedef enum logic [1:0] {
      cpu_u = 2'b00,
      cpu_s = 2'b01,
      cpu_m = 2'b11
   } cpu_mode_t;

   typedef struct packed {
      logic             paging;
      logic [ppn_w-1:0] root_ppn;
      cpu_mode_t        mode;
      logic             mxr;
      logic             sum;
   } priv_cfg_t;

   typedef struct packed {
      logic            write;
      logic [xlen-1:0] addr;
      logic [xlen-1:0] wdata;
      logic [3:0]      wstrb;
   } acc_req_t;

   typedef struct packed {
      logic [xlen-1:0] data;
      logic            fault;
      logic [4:0]      cause;
   } mmu_resp_t;

   // two-level walk view
   typedef struct packed {
      logic [vpn_w/2-1:0]  vpn1;
      logic [vpn_w/2-1:0]  vpn0;
      logic [offset_w-1:0] offset;
   } vaddr_sv32_t;

   // tlb tag view
   typedef struct packed {
      logic [vpn_w-1:0]    vpn;
      logic [offset_w-1:0] offset;
   } vaddr_page_t;

   typedef union packed {
      vaddr_sv32_t sv32;
      vaddr_page_t page;
   } vaddr_u;

   typedef struct packed {
      logic [11:0] ppn1;
      logic [9:0]  ppn0;
      logic [1:0]  rsw;
      logic [7:0]  flags;
   } pte_leaf_t;

   typedef struct packed {
      logic [ppn_w-1:0] ppn;
      logic [1:0]       rsw;
      logic [7:0]       flags;
   } pte_ptr_t;

   typedef union packed {
      pte_leaf_t leaf;
      pte_ptr_t  ptr;
   } pte_word_u;

   typedef struct packed {
      logic             valid;
      logic [vpn_w-1:0] vpn;
      logic [ppn_w-1:0] ppn;
   } tlb_entry_t;

   typedef enum logic [1:0] {
      verdict_pointer,
      verdict_leaf_ok,
      verdict_fault
   } pte_verdict_t;

endpackage

//--- hdl/mmu_pte_check.sv
`timescale 1ns/1ps

module mmu_pte_check (
   input  mmu_pkg::pte_word_u       pte,
   input  logic                     level,
   input  logic                     is_fetch,
   input  logic                     is_write,
   input  mmu_pkg::priv_cfg_t       priv,
   input  mmu_pkg::vaddr_u          vaddr,
   output mmu_pkg::pte_verdict_t    verdict,
   output logic [mmu_pkg::xlen-1:0] paddr
);
   import mmu_pkg::*;

   logic [7:0] flags;
   logic       is_leaf;
   logic       user_ok;
   logic       right_ok;
   logic       align_ok;
   logic       ad_ok;

   assign flags   = pte.leaf.flags;
   assign is_leaf = flags[pte_r] | flags[pte_x];

   // u/s page access
   always_comb begin
      case (priv.mode)
         cpu_u:   user_ok = flags[pte_u];
         cpu_s:   user_ok = !flags[pte_u] || priv.sum;
         cpu_m:   user_ok = 1'b1;
         default: user_ok = 1'b0;
      endcase
   end

   // mxr lets loads read execute-only pages
   assign right_ok = is_fetch ? flags[pte_x] :
                     is_write ? flags[pte_w] :
                     flags[pte_r] | (flags[pte_x] & priv.mxr);

   // misaligned megapage
   assign align_ok = !level || (pte.leaf.ppn0 == '0);
   assign ad_ok    = flags[pte_a] && (!is_write || flags[pte_d]);

   always_comb begin
      if (!flags[pte_v] || (flags[pte_w] && !flags[pte_r])) begin
         verdict = verdict_fault;
      end else if (!is_leaf) begin
         verdict = level ? verdict_pointer : verdict_fault;
      end else if (user_ok && right_ok && align_ok && ad_ok) begin
         verdict = verdict_leaf_ok;
      end else begin
         verdict = verdict_fault;
      end
   end

   // top two ppn1 bits fall off the 32-bit bus
   assign paddr = level ? {pte.leaf.ppn1[9:0], vaddr.sv32.vpn0, vaddr.sv32.offset}
                        : {pte.leaf.ppn1[9:0], pte.leaf.ppn0, vaddr.sv32.offset};

endmodule

//--- hdl/mmu_tlb.sv
`timescale 1ns/1ps

module mmu_tlb (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      flush,
   input  mmu_pkg::vaddr_u           lookup_vaddr,
   output logic                      hit,
   output logic [mmu_pkg::ppn_w-1:0] hit_ppn,
   input  logic                      fill,
   input  mmu_pkg::tlb_entry_t       fill_entry
);
   import mmu_pkg::*;

   tlb_entry_t             entries [tlb_entries];
   logic [tlb_entries-1:0] match;
   logic [tlb_entries-1:0] dup;
   logic [tlb_idx_w-1:0]   free_idx;

   //////////////////////////////
   // lookup

   always_comb begin
      for (int i = 0; i < tlb_entries; i++) begin
         match[i] = entries[i].valid && (entries[i].vpn == lookup_vaddr.page.vpn);
         dup[i]   = entries[i].valid && (entries[i].vpn == fill_entry.vpn);
      end
   end

   assign hit = |match;

   // tags are unique, so an or-mux is enough
   always_comb begin
      hit_ppn = '0;
      for (int i = 0; i < tlb_entries; i++) begin
         if (match[i]) begin
            hit_ppn = hit_ppn | entries[i].ppn;
         end
      end
   end

   //////////////////////////////
   // replacement

   // lowest invalid slot, slot 0 when full
   always_comb begin
      free_idx = '0;
      for (int i = tlb_entries - 1; i >= 0; i--) begin
         if (!entries[i].valid) begin
            free_idx = tlb_idx_w'(i);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rstn || flush) begin
         for (int i = 0; i < tlb_entries; i++) begin
            entries[i].valid <= 1'b0;
         end
      end else if (fill && !(|dup)) begin
         entries[free_idx] <= fill_entry;
      end
   end

endmodule

//--- hdl/mmu_walker.sv
`timescale 1ns/1ps

module mmu_walker (
   input  logic                      clk,
   input  logic                      rstn,
   input  mmu_pkg::priv_cfg_t        priv,
   input  logic                      flush_tlb,
   input  logic                      fetch_req,
   input  mmu_pkg::acc_req_t         fetch_acc,
   input  logic                      mem_req,
   input  mmu_pkg::acc_req_t         mem_acc,
   output logic                      fetch_resp,
   output logic                      mem_resp,
   output mmu_pkg::mmu_resp_t        resp,
   output logic                      bus_req,
   output mmu_pkg::acc_req_t         bus_acc,
   input  logic                      bus_resp,
   input  logic [mmu_pkg::xlen-1:0]  bus_rdata,
   output mmu_pkg::vaddr_u           tlb_vaddr,
   input  logic                      tlb_hit,
   input  logic [mmu_pkg::ppn_w-1:0] tlb_ppn,
   output logic                      tlb_fill,
   output mmu_pkg::tlb_entry_t       tlb_fill_entry,
   output mmu_pkg::pte_word_u        chk_pte,
   output logic                      chk_level,
   output logic                      chk_is_fetch,
   output logic                      chk_is_write,
   input  mmu_pkg::pte_verdict_t     chk_verdict,
   input  logic [mmu_pkg::xlen-1:0]  chk_paddr
);
   import mmu_pkg::*;

   typedef enum logic [2:0] {
      st_idle,
      st_pte1,
      st_pte0,
      st_data,
      st_recover
   } walk_state_t;

   walk_state_t state;
   logic        grant_fetch;
   acc_req_t    acc;
   acc_req_t    sel_acc;
   vaddr_u      sel_va;
   vaddr_u      cur_va;
   logic        take;
   logic        walk_resp;
   logic        walk_next;
   logic        walk_leaf;
   logic        walk_fault;
   logic        data_resp;
   logic        done;
   logic [4:0]  fault_cause;

   function automatic acc_req_t pte_read(input logic [ppn_w-1:0] base_ppn,
                                         input logic [vpn_w/2-1:0] idx);
      acc_req_t r;
      r.write = 1'b0;
      r.addr  = {base_ppn[xlen-offset_w-1:0], idx, 2'b00};
      r.wdata = '0;
      r.wstrb = '0;
      return r;
   endfunction

   function automatic acc_req_t with_addr(input acc_req_t a, input logic [xlen-1:0] addr);
      acc_req_t r;
      r      = a;
      r.addr = addr;
      return r;
   endfunction

   //////////////////////////////
   // arbitration and decode

   // fetch first
   assign sel_acc = fetch_req ? fetch_acc : mem_acc;
   assign sel_va  = sel_acc.addr;
   assign cur_va  = acc.addr;
   assign take    = (state == st_idle) && !flush_tlb && (fetch_req || mem_req);

   assign walk_resp  = bus_resp && ((state == st_pte1) || (state == st_pte0));
   assign walk_next  = walk_resp && (chk_verdict == verdict_pointer);
   assign walk_leaf  = walk_resp && (chk_verdict == verdict_leaf_ok);
   assign walk_fault = walk_resp && (chk_verdict == verdict_fault);
   assign data_resp  = bus_resp && (state == st_data);
   assign done       = data_resp || walk_fault;

   assign fault_cause = grant_fetch ? cause_fetch_pf :
                        acc.write   ? cause_store_pf : cause_load_pf;

   assign tlb_vaddr = (state == st_idle) ? sel_va : cur_va;

   assign chk_pte      = bus_rdata;
   assign chk_level    = (state == st_pte1);
   assign chk_is_fetch = grant_fetch;
   assign chk_is_write = acc.write && !grant_fetch;

   assign tlb_fill             = walk_leaf;
   assign tlb_fill_entry.valid = 1'b1;
   assign tlb_fill_entry.vpn   = cur_va.page.vpn;
   assign tlb_fill_entry.ppn   = {2'b00, chk_paddr[xlen-1:offset_w]};

   //////////////////////////////
   // control

   always_ff @(posedge clk) begin
      if (rstn) begin
         state       <= st_idle;
         grant_fetch <= 1'b0;
         bus_req     <= 1'b0;
         fetch_resp  <= 1'b0;
         mem_resp    <= 1'b0;
      end else begin
         bus_req    <= take || walk_next || walk_leaf;
         fetch_resp <= done && grant_fetch;
         mem_resp   <= done && !grant_fetch;
         if (take) begin
            grant_fetch <= fetch_req;
         end
         case (state)
            st_idle: begin
               if (take) begin
                  state <= (!priv.paging || tlb_hit) ? st_data : st_pte1;
               end
            end
            st_pte1, st_pte0: begin
               if (walk_next) begin
                  state <= st_pte0;
               end else if (walk_leaf) begin
                  state <= st_data;
               end else if (walk_fault) begin
                  state <= st_recover;
               end
            end
            st_data: begin
               if (bus_resp) begin
                  state <= st_recover;
               end
            end
            // resp pulse is out, requester drops req here
            default: state <= st_idle;
         endcase
      end
   end

   //////////////////////////////
   // payload

   always_ff @(posedge clk) begin
      if (take) begin
         acc <= sel_acc;
         if (!priv.paging) begin
            bus_acc <= sel_acc;
         end else if (tlb_hit) begin
            bus_acc <= with_addr(sel_acc, {tlb_ppn[xlen-offset_w-1:0], sel_va.page.offset});
         end else begin
            bus_acc <= pte_read(priv.root_ppn, sel_va.sv32.vpn1);
         end
      end else if (walk_next) begin
         // second level table from the pointer pte
         bus_acc <= pte_read(chk_pte.ptr.ppn, cur_va.sv32.vpn0);
      end else if (walk_leaf) begin
         bus_acc <= with_addr(acc, chk_paddr);
      end

      if (walk_fault) begin
         resp <= '{data: '0, fault: 1'b1, cause: fault_cause};
      end else if (data_resp) begin
         resp <= '{data: bus_rdata, fault: 1'b0, cause: 5'd0};
      end
   end

endmodule

//--- hdl/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
   input  logic                   clk,
   input  logic                   rstn,
   input  mmu_pkg::priv_cfg_t     priv,
   input  logic                   flush_tlb,
   input  logic                   fetch_req,
   input  mmu_pkg::acc_req_t      fetch_acc,
   input  logic                   mem_req,
   input  mmu_pkg::acc_req_t      mem_acc,
   output logic                   fetch_resp,
   output logic                   mem_resp,
   output mmu_pkg::mmu_resp_t     resp,
   output logic                   bus_req,
   output mmu_pkg::acc_req_t      bus_acc,
   input  logic                   bus_resp,
   input  logic [mmu_pkg::xlen-1:0] bus_rdata
);
   import mmu_pkg::*;

   vaddr_u           tlb_vaddr;
   logic             tlb_hit;
   logic [ppn_w-1:0] tlb_ppn;
   logic             tlb_fill;
   tlb_entry_t       tlb_fill_entry;

   pte_word_u        chk_pte;
   logic             chk_level;
   logic             chk_is_fetch;
   logic             chk_is_write;
   pte_verdict_t     chk_verdict;
   logic [xlen-1:0]  chk_paddr;

   mmu_walker walker_i (
      .clk           (clk),
      .rstn          (rstn),
      .priv          (priv),
      .flush_tlb     (flush_tlb),
      .fetch_req     (fetch_req),
      .fetch_acc     (fetch_acc),
      .mem_req       (mem_req),
      .mem_acc       (mem_acc),
      .fetch_resp    (fetch_resp),
      .mem_resp      (mem_resp),
      .resp          (resp),
      .bus_req       (bus_req),
      .bus_acc       (bus_acc),
      .bus_resp      (bus_resp),
      .bus_rdata     (bus_rdata),
      .tlb_vaddr     (tlb_vaddr),
      .tlb_hit       (tlb_hit),
      .tlb_ppn       (tlb_ppn),
      .tlb_fill      (tlb_fill),
      .tlb_fill_entry(tlb_fill_entry),
      .chk_pte       (chk_pte),
      .chk_level     (chk_level),
      .chk_is_fetch  (chk_is_fetch),
      .chk_is_write  (chk_is_write),
      .chk_verdict   (chk_verdict),
      .chk_paddr     (chk_paddr)
   );

   mmu_tlb tlb_i (
      .clk         (clk),
      .rstn        (rstn),
      .flush       (flush_tlb),
      .lookup_vaddr(tlb_vaddr),
      .hit         (tlb_hit),
      .hit_ppn     (tlb_ppn),
      .fill        (tlb_fill),
      .fill_entry  (tlb_fill_entry)
   );

   // checker sees the same address the walker presents to the tlb
   mmu_pte_check pte_check_i (
      .pte     (chk_pte),
      .level   (chk_level),
      .is_fetch(chk_is_fetch),
      .is_write(chk_is_write),
      .priv    (priv),
      .vaddr   (tlb_vaddr),
      .verdict (chk_verdict),
      .paddr   (chk_paddr)
   );

endmodule

//--- tests/tb_page_mem.sv
`timescale 1ns/1ps

module tb_page_mem (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     bus_req,
   input  mmu_pkg::acc_req_t        bus_acc,
   output logic                     bus_resp,
   output logic [mmu_pkg::xlen-1:0] bus_rdata
);
   import mmu_pkg::*;

   // page table pages live at ppn 1 and 2
   localparam logic [xlen-1:0] table_base = 32'h0000_1000;
   localparam logic [xlen-1:0] table_end  = 32'h0000_3000;
   localparam logic [xlen-1:0] data_mask  = 32'h5a5a_0000;

   logic [xlen-1:0] table_words [0:2047];
   integer          seed;
   logic            pending;
   logic [1:0]      wait_cnt;
   logic [xlen-1:0] req_addr;

   function automatic logic [xlen-1:0] read_word(input logic [xlen-1:0] addr);
      if (addr >= table_base && addr < table_end) begin
         return table_words[(addr - table_base) >> 2];
      end
      return addr ^ data_mask;
   endfunction

   initial begin
      seed      = 32'h0a20_984e;
      pending   = 1'b0;
      wait_cnt  = '0;
      req_addr  = '0;
      bus_resp  = 1'b0;
      bus_rdata = '0;
   end

   // answer 1 to 4 cycles after the request
   always @(posedge clk) begin
      if (rstn) begin
         pending  <= 1'b0;
         bus_resp <= 1'b0;
      end else begin
         bus_resp <= 1'b0;
         if (bus_req) begin
            pending  <= 1'b1;
            req_addr <= bus_acc.addr;
            wait_cnt <= 2'($unsigned($random(seed)) % 4);
         end else if (pending) begin
            if (wait_cnt == 2'd0) begin
               pending   <= 1'b0;
               bus_resp  <= 1'b1;
               bus_rdata <= read_word(req_addr);
            end else begin
               wait_cnt <= wait_cnt - 2'd1;
            end
         end
      end
   end

endmodule

//--- tests/mmu_asserts.sv
`timescale 1ns/1ps

module mmu_asserts (
   input logic clk,
   input logic rstn,
   input logic bus_req,
   input logic bus_resp,
   input logic fetch_resp,
   input logic mem_resp
);

   int   fail_count = 0;
   logic outstanding;

   // one bus read or write in flight
   always_ff @(posedge clk) begin
      if (rstn) begin
         outstanding <= 1'b0;
      end else if (bus_req) begin
         outstanding <= 1'b1;
      end else if (bus_resp) begin
         outstanding <= 1'b0;
      end
   end

   reset_quiet: assert property (@(posedge clk)
      rstn |=> !bus_req && !fetch_resp && !mem_resp)
   else begin
      $error("outputs not low after reset");
      fail_count++;
   end

   bus_req_pulse: assert property (@(posedge clk) disable iff (rstn) bus_req |=> !bus_req)
   else begin
      $error("bus_req high for more than one cycle");
      fail_count++;
   end

   fetch_resp_pulse: assert property (@(posedge clk) disable iff (rstn)
      fetch_resp |=> !fetch_resp)
   else begin
      $error("fetch_resp high for more than one cycle");
      fail_count++;
   end

   mem_resp_pulse: assert property (@(posedge clk) disable iff (rstn) mem_resp |=> !mem_resp)
   else begin
      $error("mem_resp high for more than one cycle");
      fail_count++;
   end

   resp_exclusive: assert property (@(posedge clk) disable iff (rstn)
      !(fetch_resp && mem_resp))
   else begin
      $error("fetch_resp and mem_resp high together");
      fail_count++;
   end

   single_outstanding: assert property (@(posedge clk) disable iff (rstn)
      bus_req |-> !outstanding)
   else begin
      $error("new bus_req before the previous bus_resp");
      fail_count++;
   end

endmodule

bind mmu_top mmu_asserts asserts_i (
   .clk       (clk),
   .rstn      (rstn),
   .bus_req   (bus_req),
   .bus_resp  (bus_resp),
   .fetch_resp(fetch_resp),
   .mem_resp  (mem_resp)
);

//--- tests/tb_mmu.sv
`timescale 1ns/1ps

module tb_mmu;
   import mmu_pkg::*;

   localparam int max_accesses   = 70;
   localparam int max_acc_cycles = 20;
   // twice the worst case of all accesses plus reset and setup
   localparam int timeout_cycles = 2 * max_accesses * max_acc_cycles + 200;

   localparam logic [xlen-1:0]  data_mask = 32'h5a5a_0000;
   localparam logic [ppn_w-1:0] root_ppn  = 22'd1;
   localparam logic [ppn_w-1:0] l0_ppn    = 22'd2;
   localparam logic [ppn_w-1:0] page_ppn  = 22'h100;
   localparam logic [11:0]      mega_ppn1 = 12'h004;

   // flag bits d a g u x w r v
   localparam logic [7:0] fl_ptr  = 8'h01;
   localparam logic [7:0] fl_rwx  = 8'hcf;
   localparam logic [7:0] fl_user = 8'hd7;
   localparam logic [7:0] fl_ro   = 8'hc3;
   localparam logic [7:0] fl_xo   = 8'h49;
   localparam logic [7:0] fl_nod  = 8'h47;

   localparam logic [4:0] exp_fetch_pf = 5'd12;
   localparam logic [4:0] exp_load_pf  = 5'd13;
   localparam logic [4:0] exp_store_pf = 5'd15;

   localparam int k_fetch = 0;
   localparam int k_load  = 1;
   localparam int k_store = 2;

   logic            clk;
   logic            rstn;
   priv_cfg_t       priv;
   logic            flush_tlb;
   logic            fetch_req;
   acc_req_t        fetch_acc;
   logic            mem_req;
   acc_req_t        mem_acc;
   logic            fetch_resp;
   logic            mem_resp;
   mmu_resp_t       resp;
   logic            bus_req;
   acc_req_t        bus_acc;
   logic            bus_resp;
   logic [xlen-1:0] bus_rdata;

   int              errors        = 0;
   int              passes        = 0;
   int              cycles        = 0;
   int              bus_req_total = 0;
   int              assert_fails;
   acc_req_t        last_bus_acc;

   mmu_top mmu_top_i (
      .clk       (clk),
      .rstn      (rstn),
      .priv      (priv),
      .flush_tlb (flush_tlb),
      .fetch_req (fetch_req),
      .fetch_acc (fetch_acc),
      .mem_req   (mem_req),
      .mem_acc   (mem_acc),
      .fetch_resp(fetch_resp),
      .mem_resp  (mem_resp),
      .resp      (resp),
      .bus_req   (bus_req),
      .bus_acc   (bus_acc),
      .bus_resp  (bus_resp),
      .bus_rdata (bus_rdata)
   );

   tb_page_mem page_mem_i (
      .clk      (clk),
      .rstn     (rstn),
      .bus_req  (bus_req),
      .bus_acc  (bus_acc),
      .bus_resp (bus_resp),
      .bus_rdata(bus_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // bus monitor and timeout
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (bus_req) begin
         bus_req_total <= bus_req_total + 1;
         last_bus_acc  <= bus_acc;
      end
      if (cycles >= timeout_cycles) begin
         $display("timeout: no verdict after %0d cycles", cycles);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // helpers

   function automatic logic [xlen-1:0] small_va(input int k, input logic [11:0] off);
      return {10'd1, 10'(k), off};
   endfunction

   function automatic logic [xlen-1:0] small_pa(input int k, input logic [11:0] off);
      logic [ppn_w-1:0] ppn;
      ppn = page_ppn + ppn_w'(k);
      return {ppn[19:0], off};
   endfunction

   task automatic write_pte(input logic [ppn_w-1:0] table_ppn, input int idx,
                            input logic [ppn_w-1:0] ppn, input logic [7:0] flags);
      logic [xlen-1:0] addr;
      addr = {table_ppn[19:0], 12'h000} + 32'(idx * 4);
      page_mem_i.table_words[(addr - 32'h1000) >> 2] = {ppn, 2'b00, flags};
   endtask

   task automatic build_tables();
      for (int i = 0; i < 2048; i++) begin
         page_mem_i.table_words[i] = '0;
      end
      write_pte(root_ppn, 1, l0_ppn, fl_ptr);
      write_pte(root_ppn, 2, {mega_ppn1, 10'd0}, fl_rwx);
      // megapage with ppn0 set
      write_pte(root_ppn, 3, {12'h005, 10'd1}, fl_rwx);
      write_pte(l0_ppn, 0, page_ppn, fl_rwx);
      write_pte(l0_ppn, 1, page_ppn + 22'd1, fl_user);
      write_pte(l0_ppn, 2, page_ppn + 22'd2, fl_ro);
      write_pte(l0_ppn, 3, page_ppn + 22'd3, fl_xo);
      write_pte(l0_ppn, 4, page_ppn + 22'd4, fl_nod);
      for (int k = 8; k < 24; k++) begin
         write_pte(l0_ppn, k, page_ppn + ppn_w'(k), fl_rwx);
      end
   endtask

   task automatic check_value(input string name, input string what,
                              input logic [xlen-1:0] expected, input logic [xlen-1:0] actual);
      assert (actual === expected) begin
         passes++;
      end else begin
         $display("Error %s %s: expected %h, actual %h", name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic set_priv(input logic paging, input cpu_mode_t mode, input logic mxr,
                           input logic sum);
      @(posedge clk);
      priv <= '{paging: paging, root_ppn: root_ppn, mode: mode, mxr: mxr, sum: sum};
   endtask

   task automatic pulse_flush();
      @(posedge clk);
      flush_tlb <= 1'b1;
      @(posedge clk);
      flush_tlb <= 1'b0;
   endtask

   // cause 0 means the access must succeed
   task automatic run_access(input string name, input int kind, input logic [xlen-1:0] va,
                             input logic [xlen-1:0] pa, input logic [4:0] cause,
                             input int reqs);
      acc_req_t a;
      int       start_reqs;
      logic     seen;
      logic     fault;
      a.write = (kind == k_store);
      a.addr  = va;
      a.wdata = ~va;
      a.wstrb = (kind == k_store) ? 4'hf : 4'h0;
      fault   = (cause != 5'd0);
      @(posedge clk);
      start_reqs = bus_req_total;
      if (kind == k_fetch) begin
         fetch_acc <= a;
         fetch_req <= 1'b1;
      end else begin
         mem_acc <= a;
         mem_req <= 1'b1;
      end
      seen = 1'b0;
      while (!seen) begin
         @(posedge clk);
         seen = (kind == k_fetch) ? fetch_resp : mem_resp;
      end
      fetch_req <= 1'b0;
      mem_req   <= 1'b0;
      check_value(name, "fault", 32'(fault), 32'(resp.fault));
      check_value(name, "data", fault ? 32'h0 : pa ^ data_mask, resp.data);
      check_value(name, "bus_req count", 32'(reqs), 32'(bus_req_total - start_reqs));
      if (fault) begin
         check_value(name, "cause", 32'(cause), 32'(resp.cause));
      end else begin
         check_value(name, "bus address", pa, last_bus_acc.addr);
         check_value(name, "bus write", 32'(a.write), 32'(last_bus_acc.write));
         check_value(name, "bus wdata", a.wdata, last_bus_acc.wdata);
         check_value(name, "bus wstrb", 32'(a.wstrb), 32'(last_bus_acc.wstrb));
      end
   endtask

   task automatic access_ok(input string name, input int kind, input logic [xlen-1:0] va,
                            input logic [xlen-1:0] pa, input int reqs);
      run_access(name, kind, va, pa, 5'd0, reqs);
   endtask

   task automatic access_fault(input string name, input int kind, input logic [xlen-1:0] va,
                               input logic [4:0] cause, input int reqs);
      run_access(name, kind, va, '0, cause, reqs);
   endtask

   // both requesters raise req in the same cycle
   task automatic run_dual_access(input string name, input logic [xlen-1:0] fetch_va,
                                  input logic [xlen-1:0] fetch_pa,
                                  input logic [xlen-1:0] load_va,
                                  input logic [xlen-1:0] load_pa);
      int fetch_at;
      int load_at;
      int start_reqs;
      fetch_at = -1;
      load_at  = -1;
      @(posedge clk);
      start_reqs = bus_req_total;
      fetch_acc <= '{write: 1'b0, addr: fetch_va, wdata: '0, wstrb: '0};
      mem_acc   <= '{write: 1'b0, addr: load_va, wdata: '0, wstrb: '0};
      fetch_req <= 1'b1;
      mem_req   <= 1'b1;
      while (fetch_at < 0 || load_at < 0) begin
         @(posedge clk);
         if (fetch_resp) begin
            fetch_at = cycles;
            fetch_req <= 1'b0;
            check_value(name, "fetch data", fetch_pa ^ data_mask, resp.data);
         end
         if (mem_resp) begin
            load_at = cycles;
            mem_req <= 1'b0;
            check_value(name, "load data", load_pa ^ data_mask, resp.data);
         end
      end
      check_value(name, "fetch before load", 32'd1, 32'(fetch_at < load_at));
      check_value(name, "bus_req count", 32'd2, 32'(bus_req_total - start_reqs));
   endtask

   //////////////////////////////
   // stimulus

   initial begin
      rstn      = 1'b1;
      flush_tlb = 1'b0;
      fetch_req = 1'b0;
      mem_req   = 1'b0;
      fetch_acc = '0;
      mem_acc   = '0;
      priv      = '{paging: 1'b0, root_ppn: root_ppn, mode: cpu_m, mxr: 1'b0, sum: 1'b0};
      build_tables();
      repeat (3) @(posedge clk);
      rstn <= 1'b0;

      // bare mode passes the address through
      access_ok("bare_load", k_load, 32'h0003_4560, 32'h0003_4560, 1);
      access_ok("bare_store", k_store, 32'h00ab_c008, 32'h00ab_c008, 1);
      access_ok("bare_fetch", k_fetch, 32'h0000_8100, 32'h0000_8100, 1);

      set_priv(1'b1, cpu_s, 1'b0, 1'b0);
      access_ok("sv32_walk", k_load, small_va(0, 12'h124), small_pa(0, 12'h124), 3);
      access_ok("sv32_tlb_hit", k_load, small_va(0, 12'h380), small_pa(0, 12'h380), 1);
      access_ok("sv32_fetch_hit", k_fetch, small_va(0, 12'h010), small_pa(0, 12'h010), 1);
      access_ok("sv32_store_hit", k_store, small_va(0, 12'h7fc), small_pa(0, 12'h7fc), 1);

      // megapages
      access_ok("mega_walk", k_load, {10'd2, 10'h155, 12'h0a8},
                {mega_ppn1[9:0], 10'h155, 12'h0a8}, 2);
      access_ok("mega_hit", k_load, {10'd2, 10'h155, 12'h3f0},
                {mega_ppn1[9:0], 10'h155, 12'h3f0}, 1);
      access_fault("mega_misaligned_load", k_load, {10'd3, 10'h0, 12'h0}, exp_load_pf, 1);
      access_fault("mega_misaligned_fetch", k_fetch, {10'd3, 10'h1, 12'h4}, exp_fetch_pf, 1);
      access_fault("mega_misaligned_store", k_store, {10'd3, 10'h2, 12'h8}, exp_store_pf, 1);

      //////////////////////////////
      // permission faults
      access_fault("user_page_no_sum", k_load, small_va(1, 12'h020), exp_load_pf, 2);
      set_priv(1'b1, cpu_s, 1'b0, 1'b1);
      access_ok("user_page_sum", k_load, small_va(1, 12'h020), small_pa(1, 12'h020), 3);
      set_priv(1'b1, cpu_s, 1'b0, 1'b0);
      access_fault("store_no_w", k_store, small_va(2, 12'h100), exp_store_pf, 2);
      access_fault("fetch_no_x", k_fetch, small_va(2, 12'h104), exp_fetch_pf, 2);
      access_fault("load_xonly_no_mxr", k_load, small_va(3, 12'h200), exp_load_pf, 2);
      set_priv(1'b1, cpu_s, 1'b1, 1'b0);
      access_ok("load_xonly_mxr", k_load, small_va(3, 12'h200), small_pa(3, 12'h200), 3);
      set_priv(1'b1, cpu_s, 1'b0, 1'b0);
      access_fault("store_d_clear", k_store, small_va(4, 12'h300), exp_store_pf, 2);

      //////////////////////////////
      // flush and replacement
      pulse_flush();
      access_ok("flush_rewalk", k_load, small_va(0, 12'h124), small_pa(0, 12'h124), 3);
      // 16 more pages fill the table and the last one evicts entry 0
      for (int k = 8; k < 24; k++) begin
         access_ok($sformatf("fill_page_%0d", k), k_load, small_va(k, 12'h040),
                   small_pa(k, 12'h040), 3);
      end
      access_ok("evicted_first_page", k_load, small_va(0, 12'h128), small_pa(0, 12'h128), 3);
      access_ok("second_page_hit", k_load, small_va(8, 12'h044), small_pa(8, 12'h044), 1);

      run_dual_access("fetch_wins", small_va(0, 12'h040), small_pa(0, 12'h040),
                      small_va(8, 12'h048), small_pa(8, 12'h048));

      repeat (4) @(posedge clk);
      assert_fails = mmu_top_i.asserts_i.fail_count;
      $display("checks passed: %0d, value errors: %0d, assertion errors: %0d",
               passes, errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

//--- vlog.f
hdl/mmu_pkg.sv
hdl/mmu_pte_check.sv
hdl/mmu_tlb.sv
hdl/mmu_walker.sv
hdl/mmu_top.sv
tests/tb_page_mem.sv
tests/mmu_asserts.sv
tests/tb_mmu.sv
